// File: build.f
common/fetch_pkg.sv
logic/burst_mem.sv
logic/fetch_unit.sv
icache/icache.sv
logic/fetch_top.sv
sim/clk_gen.sv
sim/icache_chk.sv
sim/fetch_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f build.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/fetch_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1

// File: sim/fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

    // worst case is a handful of runs of misses plus preload and resets
    localparam int timeout_cycles = 4000;
    localparam int preload_words  = 64;

    logic                 clk;
    logic                 reset_n;
    fetch_pkg::mem_load_t load;
    logic                 run_start;
    fetch_pkg::addr_t     run_pc;
    logic [7:0]           run_len;
    logic                 redirect;
    fetch_pkg::addr_t     redirect_pc;
    logic                 instr_valid;
    fetch_pkg::addr_t     instr_addr;
    fetch_pkg::word_t     instr;
    logic                 run_done;
    logic [15:0]          hit_count;
    logic [15:0]          miss_count;

    fetch_pkg::word_t     mem_copy [preload_words];
    logic [15:0]          lfsr;
    int                   cycle_cnt;

    // reference direct-mapped model
    logic                 model_valid [4];
    logic [11:0]          model_tag [4];
    int                   model_hits;
    int                   model_misses;

    clk_gen clk_gen_i (.clk(clk));

    fetch_top #(
        .MEM_LATENCY   (3),
        .MEM_ADDR_BITS (8)
    ) dut_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .load        (load),
        .run_start   (run_start),
        .run_pc      (run_pc),
        .run_len     (run_len),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_valid (instr_valid),
        .instr_addr  (instr_addr),
        .instr       (instr),
        .run_done    (run_done),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, actual, expected);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    // taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic apply_reset();
        reset_n = 1'b1;
        repeat (10) @(negedge clk);
        reset_n = 1'b0;
        for (int i = 0; i < 4; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = '0;
        end
        model_hits   = 0;
        model_misses = 0;
    endtask

    task automatic preload_memory();
        fetch_pkg::word_t w;
        for (int a = 0; a < preload_words; a++) begin
            w = '0;
            for (int b = 0; b < 16; b++) begin
                lfsr = lfsr_next(lfsr);
                w    = {w[14:0], lfsr[0]};
            end
            mem_copy[a] = w;
            load.strobe = 1'b1;
            load.addr   = 16'(a);
            load.data   = w;
            @(negedge clk);
        end
        load = '0;
        @(negedge clk);
    endtask

    task automatic model_lookup(input logic [15:0] addr);
        int s;
        s = addr[3:2];
        if (model_valid[s] && model_tag[s] == addr[15:4]) begin
            model_hits++;
        end else begin
            model_misses++;
            model_valid[s] = 1'b1;
            model_tag[s]   = addr[15:4];
        end
    endtask

    // words up to the one in flight follow the run, the rest follow the redirect target
    function automatic logic [15:0] expected_addr(input logic [15:0] start_pc, input int idx,
                                                  input int redirect_after,
                                                  input logic [15:0] target);
        if (redirect_after < 0 || idx <= redirect_after + 1) begin
            return start_pc + 16'(idx);
        end
        return target + 16'(idx - redirect_after - 2);
    endfunction

    // redirect_after is the index of the word after which a redirect is sent, -1 for none
    task automatic fetch_run(input logic [15:0] start_pc, input int len,
                             input int redirect_after, input logic [15:0] target);
        int          n;
        logic        redirect_due;
        logic [15:0] exp_addr;
        run_start    = 1'b1;
        run_pc       = start_pc;
        run_len      = 8'(len);
        n            = 0;
        redirect_due = 1'b0;
        while (n < len) begin
            @(negedge clk);
            run_start = 1'b0;
            redirect  = 1'b0;
            if (redirect_due) begin
                redirect     = 1'b1;
                redirect_pc  = target;
                redirect_due = 1'b0;
            end
            check_equal("run_done", 32'(run_done), 32'(instr_valid && n == len - 1));
            if (instr_valid) begin
                exp_addr = expected_addr(start_pc, n, redirect_after, target);
                check_equal("instr_addr", 32'(instr_addr), 32'(exp_addr));
                check_equal("instr", 32'(instr), 32'(mem_copy[exp_addr]));
                model_lookup(exp_addr);
                if (n == redirect_after) begin
                    redirect_due = 1'b1;
                end
                n++;
            end
        end
        check_equal("hit_count", 32'(hit_count), 32'(model_hits));
        check_equal("miss_count", 32'(miss_count), 32'(model_misses));
        // fetch unit returns to idle at this edge
        @(negedge clk);
    endtask

    task automatic first_fetch_then_hit();
        fetch_run(16'd5, 1, -1, 16'd0);
        check_equal("miss_count", 32'(miss_count), 32'd1);
        check_equal("hit_count", 32'(hit_count), 32'd0);
        fetch_run(16'd6, 1, -1, 16'd0);
        check_equal("miss_count", 32'(miss_count), 32'd1);
        check_equal("hit_count", 32'(hit_count), 32'd1);
    endtask

    task automatic sequential_run();
        logic [15:0] base_hits;
        logic [15:0] base_misses;
        base_hits   = hit_count;
        base_misses = miss_count;
        fetch_run(16'd16, 12, -1, 16'd0);
        check_equal("miss_count", 32'(miss_count - base_misses), 32'd3);
        check_equal("hit_count", 32'(hit_count - base_hits), 32'd9);
    endtask

    task automatic set_conflict();
        logic [15:0] base_hits;
        logic [15:0] base_misses;
        base_hits   = hit_count;
        base_misses = miss_count;
        fetch_run(16'd0, 1, -1, 16'd0);
        fetch_run(16'd16, 1, -1, 16'd0);
        fetch_run(16'd0, 1, -1, 16'd0);
        check_equal("miss_count", 32'(miss_count - base_misses), 32'd3);
        check_equal("hit_count", 32'(hit_count - base_hits), 32'd0);
    endtask

    task automatic redirect_mid_run();
        fetch_run(16'd32, 8, 1, 16'd48);
    endtask

    // 48 sits in set 0 from the redirect run
    task automatic reset_clears_cache();
        apply_reset();
        check_equal("hit_count", 32'(hit_count), 32'd0);
        check_equal("miss_count", 32'(miss_count), 32'd0);
        fetch_run(16'd48, 1, -1, 16'd0);
        check_equal("miss_count", 32'(miss_count), 32'd1);
        check_equal("hit_count", 32'(hit_count), 32'd0);
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the tests did not finish", timeout_cycles);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        reset_n     = 1'b1;
        load        = '0;
        run_start   = 1'b0;
        run_pc      = '0;
        run_len     = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        lfsr        = 16'd84;
        @(negedge clk);
        apply_reset();
        preload_memory();
        first_fetch_then_hit();
        sequential_run();
        set_conflict();
        redirect_mid_run();
        reset_clears_cache();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/icache_chk.sv
`timescale 1ns/100ps
`default_nettype none

module icache_chk (
    input wire                           clk,
    input wire                           reset_n,
    input wire fetch_pkg::icache_state_e state,
    input wire fetch_pkg::fetch_req_t    fetch_req,
    input wire fetch_pkg::fetch_resp_t   fetch_resp,
    input wire fetch_pkg::mem_req_t      mem_req,
    input wire                           lookup_hit
);

    // a burst request leaves from idle for the line of the lookup that just missed
    mem_req_in_idle: assert property (@(posedge clk) disable iff (reset_n)
        mem_req.strobe |-> (state == fetch_pkg::icache_idle)
            && $past(fetch_req.strobe && !lookup_hit)
            && (mem_req.addr == {$past(fetch_req.addr[15:2]), 2'b00}))
        else $error("mem_req raised outside idle or without a missed lookup");

    hit_answers_next_cycle: assert property (@(posedge clk) disable iff (reset_n)
        (state == fetch_pkg::icache_idle && fetch_req.strobe && lookup_hit)
        |=> (fetch_resp.strobe && fetch_resp.addr == $past(fetch_req.addr)))
        else $error("hit response missing one cycle after request");

    // the fetch unit must be waiting while a line fills
    no_req_during_fill: assert property (@(posedge clk) disable iff (reset_n)
        fetch_req.strobe |-> state != fetch_pkg::icache_fill)
        else $error("fetch_req arrived during fill");

endmodule

bind icache icache_chk icache_chk_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .state      (state),
    .fetch_req  (fetch_req),
    .fetch_resp (fetch_resp),
    .mem_req    (mem_req),
    .lookup_hit (lookup_hit)
);

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
    parameter real HALF_PERIOD = 5.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter int MEM_LATENCY   = 3,
    parameter int MEM_ADDR_BITS = 8
) (
    input  wire                       clk,
    input  wire                       reset_n,
    input  wire fetch_pkg::mem_load_t load,
    input  wire                       run_start,
    input  wire fetch_pkg::addr_t     run_pc,
    input  wire [7:0]                 run_len,
    input  wire                       redirect,
    input  wire fetch_pkg::addr_t     redirect_pc,
    output logic                      instr_valid,
    output fetch_pkg::addr_t          instr_addr,
    output fetch_pkg::word_t          instr,
    output logic                      run_done,
    output logic [15:0]               hit_count,
    output logic [15:0]               miss_count
);

    fetch_pkg::fetch_req_t  fetch_req;
    fetch_pkg::fetch_resp_t fetch_resp;
    fetch_pkg::mem_req_t    mem_req;
    fetch_pkg::mem_rd_t     mem_rd;

    fetch_unit fetch_unit_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .run_start   (run_start),
        .run_pc      (run_pc),
        .run_len     (run_len),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_resp  (fetch_resp),
        .fetch_req   (fetch_req),
        .instr_valid (instr_valid),
        .instr_addr  (instr_addr),
        .instr       (instr),
        .run_done    (run_done)
    );

    icache icache_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .fetch_req  (fetch_req),
        .mem_rd     (mem_rd),
        .fetch_resp (fetch_resp),
        .mem_req    (mem_req),
        .hit_count  (hit_count),
        .miss_count (miss_count)
    );

    burst_mem #(
        .MEM_LATENCY   (MEM_LATENCY),
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) burst_mem_i (
        .clk     (clk),
        .reset_n (reset_n),
        .load    (load),
        .mem_req (mem_req),
        .mem_rd  (mem_rd)
    );

endmodule

`default_nettype wire

// File: icache/icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache (
    input  wire                     clk,
    input  wire                     reset_n,
    input  wire fetch_pkg::fetch_req_t fetch_req,
    input  wire fetch_pkg::mem_rd_t    mem_rd,
    output fetch_pkg::fetch_resp_t  fetch_resp,
    output fetch_pkg::mem_req_t     mem_req,
    output logic [15:0]             hit_count,
    output logic [15:0]             miss_count
);

    fetch_pkg::cache_line_t   lines [fetch_pkg::num_sets];
    fetch_pkg::icache_state_e state;

    // lookup fields of the incoming request
    fetch_pkg::tag_t          req_tag;
    fetch_pkg::set_idx_t      req_set;
    logic                     lookup_hit;

    // request being served, kept for the response and the fill
    fetch_pkg::addr_t         req_addr_q;
    fetch_pkg::set_idx_t      cur_set;
    fetch_pkg::offset_t       cur_off;
    fetch_pkg::cache_line_t   cur_line;

    logic                     hit_q;
    logic                     miss_q;
    logic [1:0]               fill_cnt;
    fetch_pkg::line_data_t    fill_buf;
    logic                     fill_last;

    assign req_tag = fetch_req.addr[fetch_pkg::word_bits-1 -: fetch_pkg::tag_bits];
    assign req_set = fetch_req.addr[3:2];

    assign lookup_hit = lines[req_set].valid && (lines[req_set].tag == req_tag);

    assign cur_set  = req_addr_q[3:2];
    assign cur_off  = req_addr_q[1:0];
    assign cur_line = lines[cur_set];

    assign fill_last = (state == fetch_pkg::icache_fill) && mem_rd.strobe && (fill_cnt == 2'd3);

    // hits answer one cycle after lookup, misses answer from the freshly written line
    assign fetch_resp.strobe = hit_q || (state == fetch_pkg::icache_respond);
    assign fetch_resp.addr   = req_addr_q;
    assign fetch_resp.instr  = cur_line.data[cur_off*fetch_pkg::word_bits +: fetch_pkg::word_bits];

    // miss_q is only ever set in idle, so the burst request leaves from idle
    assign mem_req.strobe = miss_q;
    assign mem_req.addr   = {req_addr_q[fetch_pkg::word_bits-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state      <= fetch_pkg::icache_idle;
            hit_q      <= 1'b0;
            miss_q     <= 1'b0;
            fill_cnt   <= 2'd0;
            hit_count  <= 16'd0;
            miss_count <= 16'd0;
        end else begin
            hit_q <= 1'b0;
            case (state)
                fetch_pkg::icache_idle: begin
                    if (miss_q) begin
                        miss_q   <= 1'b0;
                        fill_cnt <= 2'd0;
                        state    <= fetch_pkg::icache_fill;
                    end else if (fetch_req.strobe) begin
                        if (lookup_hit) begin
                            hit_q     <= 1'b1;
                            hit_count <= hit_count + 16'd1;
                        end else begin
                            miss_q     <= 1'b1;
                            miss_count <= miss_count + 16'd1;
                        end
                    end
                end
                fetch_pkg::icache_fill: begin
                    if (mem_rd.strobe) begin
                        fill_cnt <= fill_cnt + 2'd1;
                    end
                    if (fill_last) begin
                        state <= fetch_pkg::icache_respond;
                    end
                end
                fetch_pkg::icache_respond: begin
                    state <= fetch_pkg::icache_idle;
                end
                default: begin
                    state <= fetch_pkg::icache_idle;
                end
            endcase
        end
    end

    // latch the address of every lookup
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::icache_idle && !miss_q && fetch_req.strobe) begin
            req_addr_q <= fetch_req.addr;
        end
    end

    // burst words 0..2 wait here, word 3 goes straight into the line
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::icache_fill && mem_rd.strobe) begin
            fill_buf[fill_cnt*fetch_pkg::word_bits +: fetch_pkg::word_bits] <= mem_rd.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < fetch_pkg::num_sets; i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (fill_last) begin
            lines[cur_set].valid <= 1'b1;
            lines[cur_set].tag   <= req_addr_q[fetch_pkg::word_bits-1 -: fetch_pkg::tag_bits];
            lines[cur_set].data  <= {mem_rd.data, fill_buf[3*fetch_pkg::word_bits-1:0]};
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        run_start,
    input  wire fetch_pkg::addr_t      run_pc,
    input  wire [7:0]                  run_len,
    input  wire                        redirect,
    input  wire fetch_pkg::addr_t      redirect_pc,
    input  wire fetch_pkg::fetch_resp_t fetch_resp,
    output fetch_pkg::fetch_req_t      fetch_req,
    output logic                       instr_valid,
    output fetch_pkg::addr_t           instr_addr,
    output fetch_pkg::word_t           instr,
    output logic                       run_done
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::addr_t        pc;
    logic [7:0]              remain;

    assign fetch_req.strobe = (state == fetch_pkg::fetch_request);
    assign fetch_req.addr   = pc;

    // responses pass straight through to the core side
    assign instr_valid = fetch_resp.strobe && (state == fetch_pkg::fetch_wait_resp);
    assign instr_addr  = fetch_resp.addr;
    assign instr       = fetch_resp.instr;
    assign run_done    = instr_valid && (remain == 8'd1);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state  <= fetch_pkg::fetch_idle;
            remain <= 8'd0;
        end else begin
            case (state)
                fetch_pkg::fetch_idle: begin
                    // an empty run never leaves idle
                    if (run_start && run_len != 8'd0) begin
                        remain <= run_len;
                        state  <= fetch_pkg::fetch_request;
                    end
                end
                fetch_pkg::fetch_request: begin
                    state <= fetch_pkg::fetch_wait_resp;
                end
                fetch_pkg::fetch_wait_resp: begin
                    if (fetch_resp.strobe) begin
                        remain <= remain - 8'd1;
                        if (remain == 8'd1) begin
                            state <= fetch_pkg::fetch_idle;
                        end else begin
                            state <= fetch_pkg::fetch_request;
                        end
                    end
                end
                default: begin
                    state <= fetch_pkg::fetch_idle;
                end
            endcase
        end
    end

    // a redirect wins over the post-request increment
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::fetch_idle) begin
            if (run_start) begin
                pc <= run_pc;
            end
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (state == fetch_pkg::fetch_request) begin
            pc <= pc + 16'd1;
        end
    end

endmodule

`default_nettype wire

// File: logic/burst_mem.sv
`timescale 1ns/100ps
`default_nettype none

module burst_mem #(
    parameter int MEM_LATENCY   = 3,
    parameter int MEM_ADDR_BITS = 8
) (
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire fetch_pkg::mem_load_t load,
    input  wire fetch_pkg::mem_req_t  mem_req,
    output fetch_pkg::mem_rd_t        mem_rd
);

    localparam int lat_bits = $clog2(MEM_LATENCY + 1);

    fetch_pkg::word_t         mem [2**MEM_ADDR_BITS];

    logic                     active;
    logic [lat_bits-1:0]      wait_cnt;
    logic [1:0]               beat;
    logic [MEM_ADDR_BITS-3:0] base_q;
    logic [MEM_ADDR_BITS-1:0] rd_addr;
    logic                     beat_now;

    // one beat per cycle once the latency has run out
    assign beat_now = active && (wait_cnt == '0);
    assign rd_addr  = {base_q, beat};

    assign mem_rd.strobe = beat_now;
    assign mem_rd.data   = mem[rd_addr];

    // preload port, only the low address bits index the array
    always_ff @(posedge clk) begin
        if (load.strobe) begin
            mem[load.addr[MEM_ADDR_BITS-1:0]] <= load.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            active   <= 1'b0;
            wait_cnt <= '0;
            beat     <= 2'd0;
        end else if (mem_req.strobe) begin
            active   <= 1'b1;
            wait_cnt <= lat_bits'(MEM_LATENCY - 1);
            beat     <= 2'd0;
        end else if (active) begin
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else begin
                beat <= beat + 2'd1;
                if (beat == 2'd3) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // line base, the word offset comes from the beat counter
    always_ff @(posedge clk) begin
        if (mem_req.strobe) begin
            base_q <= mem_req.addr[MEM_ADDR_BITS-1:2];
        end
    end

endmodule

`default_nettype wire

// File: common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // cache geometry
    localparam int word_bits  = 16;
    localparam int line_words = 4;
    localparam int num_sets   = 4;
    localparam int tag_bits   = 12;

    typedef logic [word_bits-1:0]             addr_t;
    typedef logic [word_bits-1:0]             word_t;
    typedef logic [tag_bits-1:0]              tag_t;
    typedef logic [$clog2(num_sets)-1:0]      set_idx_t;
    typedef logic [$clog2(line_words)-1:0]    offset_t;

    // word 0 sits in the low bits
    typedef logic [line_words*word_bits-1:0]  line_data_t;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        line_data_t data;
    } cache_line_t;

    // fetch unit to cache
    typedef struct packed {
        logic  strobe;
        addr_t addr;
    } fetch_req_t;

    // cache back to fetch unit
    typedef struct packed {
        logic  strobe;
        addr_t addr;
        word_t instr;
    } fetch_resp_t;

    // line base address, low offset bits are zero
    typedef struct packed {
        logic  strobe;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic  strobe;
        word_t data;
    } mem_rd_t;

    // memory preload, one word per strobe
    typedef struct packed {
        logic  strobe;
        addr_t addr;
        word_t data;
    } mem_load_t;

    typedef enum logic [1:0] {
        icache_idle,
        icache_fill,
        icache_respond
    } icache_state_e;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_request,
        fetch_wait_resp
    } fetch_state_e;

endpackage

`default_nettype wire
